// ==== src.f ====
+incdir+.
isa_pkg.sv
core_pkg.sv
ir_controller.sv
regfile.sv
alu32.sv
operand_select.sv
core_top.sv
core_assertions.sv
tb_core.sv

// ==== Makefile ====
BIN := obj_dir/Vtb_core

.PHONY: all run clean

all: $(BIN)

$(BIN): src.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f src.f

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== tb_core.sv ====
`include "cpu_defines.svh"
`default_nettype none

module tb_core;
  timeunit 1ns;
  timeprecision 1ps;

  logic                  clk;
  logic                  rst;
  logic                  system_enable;
  logic                  im_en;
  logic                  im_read;
  core_pkg::pc_t         im_addr;
  isa_pkg::word_t        instruction;
  logic                  dm_en;
  logic                  dm_read;
  logic                  dm_write;
  logic [`DM_ADDR_W-1:0] dm_addr;
  isa_pkg::word_t        dm_wdata;
  isa_pkg::word_t        dm_rdata;
  logic [`CYCLE_W-1:0]   cycle_cnt;
  logic [`INS_W-1:0]     ins_cnt;
  logic                  halted;

  logic [31:0]           seed;
  int                    limit;
  int                    run_cycles;
  core_pkg::pc_t         fetch_pc;
  isa_pkg::word_t        prog [$];
  isa_pkg::word_t        imem [1024];
  isa_pkg::word_t        dmem [4096];
  isa_pkg::word_t        model_regs [`REG_CNT];
  isa_pkg::word_t        model_mem [4096];
  logic [`DM_ADDR_W-1:0] exp_addr [$];
  isa_pkg::word_t        exp_data [$];

  core_top dut0 (.*);

  bind ir_controller core_assertions asrt0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_stop(input string why);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      fail_stop("value mismatch");
    end
  endtask

  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic isa_pkg::word_t reg_op(
    input isa_pkg::alu_sub_e sub,
    input isa_pkg::reg_idx_t rt,
    input isa_pkg::reg_idx_t ra,
    input isa_pkg::reg_idx_t rb
  );
    return {1'b0, isa_pkg::OP_ALU, rt, ra, rb, 2'b00, 3'b000, sub};
  endfunction

  function automatic isa_pkg::word_t imm_op(
    input isa_pkg::opcode_e  op,
    input isa_pkg::reg_idx_t rt,
    input isa_pkg::reg_idx_t ra,
    input isa_pkg::imm15_t   imm
  );
    return {1'b0, op, rt, ra, imm};
  endfunction

  // sv = 2 sits in imm15[9:8], so the byte offset is (512 + k) * 4.
  function automatic isa_pkg::imm15_t mem_offset(input int k);
    return {5'd0, 2'd2, 8'(k)};
  endfunction

  function automatic void build_program();
    isa_pkg::alu_sub_e subs [8];
    isa_pkg::opcode_e  imm_ops [3];
    logic [31:0]       r;
    int                sel;
    subs = '{isa_pkg::SUB_ADD, isa_pkg::SUB_SUB, isa_pkg::SUB_AND, isa_pkg::SUB_OR,
             isa_pkg::SUB_XOR, isa_pkg::SUB_SLLI, isa_pkg::SUB_SRLI, isa_pkg::SUB_ROTRI};
    imm_ops = '{isa_pkg::OP_ADDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI};
    for (int i = 0; i < 32; i++) begin
      r = next_rand();
      prog.push_back({1'b0, isa_pkg::OP_MOVI, 5'(i), r[19:0]});
    end
    for (int i = 0; i < 120; i++) begin
      r = next_rand();
      sel = int'(r[31:28]) % 12;
      if (sel < 8) begin
        prog.push_back(reg_op(subs[sel], r[24:20], r[19:15], r[14:10]));
      end else if (sel == 11) begin
        prog.push_back({1'b0, isa_pkg::OP_MOVI, r[24:20], r[19:0]});
      end else begin
        prog.push_back(imm_op(imm_ops[sel-8], r[24:20], r[19:15], r[14:0]));
      end
    end
    // dump all registers with r0 as the base and r0 itself last.
    for (int k = 1; k < 32; k++) begin
      prog.push_back(imm_op(isa_pkg::OP_SWI, 5'(k), 5'd0, mem_offset(k)));
    end
    prog.push_back(imm_op(isa_pkg::OP_SWI, 5'd0, 5'd0, mem_offset(0)));
    // reload in reversed register order, then store to a fresh area.
    for (int k = 1; k < 32; k++) begin
      prog.push_back(imm_op(isa_pkg::OP_LWI, 5'(32 - k), 5'd0, mem_offset(k)));
    end
    for (int k = 1; k < 32; k++) begin
      prog.push_back(imm_op(isa_pkg::OP_SWI, 5'(k), 5'd0, mem_offset(k + 64)));
    end
    prog.push_back({1'b0, isa_pkg::OP_HALT, 25'd0});
  endfunction

  // executes one instruction on the model state and returns its cycle count.
  function automatic int model_step(input isa_pkg::word_t ins);
    isa_pkg::opcode_e  op;
    isa_pkg::reg_idx_t rt;
    isa_pkg::word_t    a;
    isa_pkg::word_t    b;
    isa_pkg::word_t    imm_se;
    isa_pkg::word_t    ea;
    logic [4:0]        sh;
    op = isa_pkg::opcode_e'(ins[30:25]);
    rt = ins[24:20];
    a = model_regs[ins[19:15]];
    b = model_regs[ins[14:10]];
    sh = ins[14:10];
    imm_se = {{17{ins[14]}}, ins[14:0]};
    ea = a + (imm_se << ins[9:8]);
    case (op)
      isa_pkg::OP_ALU: begin
        case (isa_pkg::alu_sub_e'(ins[4:0]))
          isa_pkg::SUB_ADD:   model_regs[rt] = a + b;
          isa_pkg::SUB_SUB:   model_regs[rt] = a - b;
          isa_pkg::SUB_AND:   model_regs[rt] = a & b;
          isa_pkg::SUB_OR:    model_regs[rt] = a | b;
          isa_pkg::SUB_XOR:   model_regs[rt] = a ^ b;
          isa_pkg::SUB_SLLI:  model_regs[rt] = a << sh;
          isa_pkg::SUB_SRLI:  model_regs[rt] = a >> sh;
          isa_pkg::SUB_ROTRI: model_regs[rt] = isa_pkg::word_t'({a, a} >> sh);
          default:            model_regs[rt] = '0;
        endcase
      end
      isa_pkg::OP_ADDI: model_regs[rt] = a + imm_se;
      isa_pkg::OP_ORI:  model_regs[rt] = a | {17'd0, ins[14:0]};
      isa_pkg::OP_XORI: model_regs[rt] = a ^ {17'd0, ins[14:0]};
      isa_pkg::OP_MOVI: model_regs[rt] = {{12{ins[19]}}, ins[19:0]};
      isa_pkg::OP_LWI: begin
        model_regs[rt] = model_mem[ea[11:0]];
        return 5;
      end
      isa_pkg::OP_SWI: begin
        model_mem[ea[11:0]] = model_regs[rt];
        exp_addr.push_back(ea[11:0]);
        exp_data.push_back(model_regs[rt]);
        return 4;
      end
      default: return 2;
    endcase
    return 3;
  endfunction

  // synchronous memories answer one cycle after the strobe.
  always @(posedge clk) begin
    if (im_en && im_read) begin
      instruction <= imem[im_addr];
    end
    if (dm_en && dm_read) begin
      dm_rdata <= dmem[dm_addr];
    end
    if (dm_en && dm_write) begin
      dmem[dm_addr] <= dm_wdata;
    end
  end

  // fetches run through the program in order.
  always @(negedge clk) begin
    logic [`DM_ADDR_W-1:0] a;
    isa_pkg::word_t        d;
    if (im_en && im_read) begin
      check_eq(im_addr, fetch_pc, "fetch address");
      fetch_pc = fetch_pc + 1'b1;
    end
    if (dm_en && dm_write) begin
      if (exp_addr.size() == 0) begin
        $display("store at %0t ns with no store left in the reference program", $time);
        fail_stop("unexpected store");
      end else begin
        a = exp_addr.pop_front();
        d = exp_data.pop_front();
        check_eq(dm_addr, a, "store address");
        check_eq(dm_wdata, d, "store data");
      end
    end
  end

  always @(posedge clk) begin
    if (system_enable && !halted) begin
      run_cycles <= run_cycles + 1;
      if (run_cycles >= limit) begin
        $display("timeout after %0d cycles, the core never halted", run_cycles);
        fail_stop("timeout");
      end
    end
  end

  initial begin
    int exp_cycles;
    int exp_ins;
    rst = 1'b1;
    system_enable = 1'b0;
    instruction = '0;
    dm_rdata = '0;
    seed = 32'h3bce_6e86;
    run_cycles = 0;
    fetch_pc = '0;
    exp_cycles = 0;
    exp_ins = 0;
    build_program();
    limit = 6 * prog.size() + 100;
    for (int i = 0; i < 1024; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : {1'b0, isa_pkg::OP_HALT, 15'd0, 10'(i)};
    end
    for (int i = 0; i < 4096; i++) begin
      dmem[i] = {20'hd5a00, 12'(i)};
      model_mem[i] = {20'hd5a00, 12'(i)};
    end
    for (int i = 0; i < `REG_CNT; i++) begin
      model_regs[i] = '0;
    end
    foreach (prog[i]) begin
      exp_cycles += model_step(prog[i]);
      if (prog[i][30:25] == isa_pkg::OP_HALT) begin
        break;
      end
      exp_ins++;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    repeat (20) begin
      @(negedge clk);
      check_eq({im_en, im_read, dm_en, dm_read, dm_write}, '0, "strobes while disabled");
      check_eq(cycle_cnt, '0, "cycle_cnt while disabled");
    end
    @(posedge clk);
    system_enable <= 1'b1;
    while (!halted) begin
      @(negedge clk);
    end
    check_eq(ins_cnt, exp_ins, "ins_cnt at halt");
    check_eq(cycle_cnt, exp_cycles, "cycle_cnt at halt");
    check_eq(exp_addr.size(), 0, "stores still outstanding");
    repeat (20) begin
      @(negedge clk);
      check_eq({im_en, im_read, dm_en, dm_read, dm_write}, '0, "strobes after halt");
      check_eq(halted, 1'b1, "halted");
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== core_assertions.sv ====
`default_nettype none

module core_assertions (
  input logic clk,
  input logic rst,
  input logic im_en,
  input logic im_read,
  input logic dm_en,
  input logic dm_read,
  input logic dm_write,
  input logic halted
);
  timeunit 1ns;
  timeprecision 1ps;

  logic any_im;
  logic any_dm;

  assign any_im = im_en || im_read;
  assign any_dm = dm_en || dm_read || dm_write;

  dm_rd_wr_excl: assert property (@(posedge clk) !(dm_read && dm_write))
    else $error("data read and write strobes high in the same cycle");

  im_dm_excl: assert property (@(posedge clk) !(any_im && any_dm))
    else $error("instruction and data strobes high in the same cycle");

  // first reset edge settles the state register.
  quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !(any_im || any_dm))
    else $error("memory strobe high during reset");

  halt_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else $error("halted dropped after being set");

endmodule

`default_nettype wire

// ==== core_top.sv ====
`include "cpu_defines.svh"
`default_nettype none

module core_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  system_enable,
  output logic                  im_en,
  output logic                  im_read,
  output core_pkg::pc_t         im_addr,
  input  isa_pkg::word_t        instruction,
  output logic                  dm_en,
  output logic                  dm_read,
  output logic                  dm_write,
  output logic [`DM_ADDR_W-1:0] dm_addr,
  output isa_pkg::word_t        dm_wdata,
  input  isa_pkg::word_t        dm_rdata,
  output logic [`CYCLE_W-1:0]   cycle_cnt,
  output logic [`INS_W-1:0]     ins_cnt,
  output logic                  halted
);
  logic               reg_write;
  isa_pkg::reg_idx_t  read_addr1;
  isa_pkg::reg_idx_t  read_addr2;
  isa_pkg::reg_idx_t  addr_t;
  isa_pkg::opcode_e   opcode;
  isa_pkg::alu_sub_e  sub_op;
  isa_pkg::sv_t       sv;
  isa_pkg::imm5_t     imm5;
  isa_pkg::imm15_t    imm15;
  isa_pkg::imm20_t    imm20;
  core_pkg::imm_sel_e imm_sel;
  core_pkg::src_sel_e src_sel1;
  core_pkg::src_sel_e src_sel2;
  core_pkg::wb_sel_e  wb_sel;
  isa_pkg::word_t     read_data1;
  isa_pkg::word_t     read_data2;
  isa_pkg::word_t     src1;
  isa_pkg::word_t     src2;
  isa_pkg::word_t     alu_result;
  isa_pkg::word_t     write_data;

  ir_controller ctrl0 (.*);

  // the store source goes straight out as write data.
  regfile rf0 (
    .*,
    .write       (reg_write),
    .read_data_t (dm_wdata)
  );

  // overflow has no consumer in this core.
  alu32 alu0 (
    .*,
    .result   (alu_result),
    .overflow ()
  );

  operand_select sel0 (.*);

  assign dm_addr = alu_result[`DM_ADDR_W-1:0];

endmodule

`default_nettype wire

// ==== operand_select.sv ====
`default_nettype none

module operand_select (
  input  isa_pkg::imm5_t     imm5,
  input  isa_pkg::imm15_t    imm15,
  input  isa_pkg::imm20_t    imm20,
  input  core_pkg::imm_sel_e imm_sel,
  input  core_pkg::src_sel_e src_sel1,
  input  core_pkg::src_sel_e src_sel2,
  input  isa_pkg::word_t     read_data1,
  input  isa_pkg::word_t     read_data2,
  input  isa_pkg::word_t     alu_result,
  input  isa_pkg::word_t     dm_rdata,
  input  core_pkg::wb_sel_e  wb_sel,
  output isa_pkg::word_t     src1,
  output isa_pkg::word_t     src2,
  output isa_pkg::word_t     write_data
);
  isa_pkg::word_t imm;

  function automatic isa_pkg::word_t pick_src(
    input core_pkg::src_sel_e sel,
    input isa_pkg::word_t     data,
    input isa_pkg::word_t     imm_val
  );
    case (sel)
      core_pkg::SRC_REG: return data;
      core_pkg::SRC_IMM: return imm_val;
      default:           return '0;
    endcase
  endfunction

  always_comb begin
    case (imm_sel)
      core_pkg::IMM_ZE5:  imm = {27'd0, imm5};
      core_pkg::IMM_SE15: imm = {{17{imm15[14]}}, imm15};
      core_pkg::IMM_ZE15: imm = {17'd0, imm15};
      default:            imm = {{12{imm20[19]}}, imm20};
    endcase
  end

  assign src1 = pick_src(src_sel1, read_data1, imm);
  assign src2 = pick_src(src_sel2, read_data2, imm);

  assign write_data = (wb_sel == core_pkg::WB_DMEM) ? dm_rdata : alu_result;

endmodule

`default_nettype wire

// ==== alu32.sv ====
`default_nettype none

module alu32 (
  input  isa_pkg::word_t    src1,
  input  isa_pkg::word_t    src2,
  input  isa_pkg::opcode_e  opcode,
  input  isa_pkg::alu_sub_e sub_op,
  input  isa_pkg::sv_t      sv,
  output isa_pkg::word_t    result,
  output logic              overflow
);
  logic           mem_op;
  logic [4:0]     shamt;
  logic           add_ovf;
  logic           sub_ovf;
  isa_pkg::word_t addend;
  isa_pkg::word_t sum;
  isa_pkg::word_t diff;
  isa_pkg::word_t rot;

  assign mem_op = (opcode == isa_pkg::OP_LWI) || (opcode == isa_pkg::OP_SWI);
  // load and store offsets are scaled by sv.
  assign addend  = mem_op ? (src2 << sv) : src2;
  assign sum     = src1 + addend;
  assign diff    = src1 - src2;
  assign add_ovf = (src1[31] == addend[31]) && (sum[31] != src1[31]);
  assign sub_ovf = (src1[31] != src2[31]) && (diff[31] != src1[31]);
  assign shamt   = src2[4:0];
  assign rot     = (src1 >> shamt) | (src1 << (6'd32 - {1'b0, shamt}));

  always_comb begin
    result   = '0;
    overflow = 1'b0;
    case (opcode)
      isa_pkg::OP_ALU: begin
        case (sub_op)
          isa_pkg::SUB_ADD: begin
            result   = sum;
            overflow = add_ovf;
          end
          isa_pkg::SUB_SUB: begin
            result   = diff;
            overflow = sub_ovf;
          end
          isa_pkg::SUB_AND:   result = src1 & src2;
          isa_pkg::SUB_OR:    result = src1 | src2;
          isa_pkg::SUB_XOR:   result = src1 ^ src2;
          isa_pkg::SUB_SLLI:  result = src1 << shamt;
          isa_pkg::SUB_SRLI:  result = src1 >> shamt;
          isa_pkg::SUB_ROTRI: result = rot;
          default:            result = '0;
        endcase
      end
      isa_pkg::OP_ADDI: begin
        result   = sum;
        overflow = add_ovf;
      end
      isa_pkg::OP_LWI, isa_pkg::OP_SWI: result = sum;
      isa_pkg::OP_ORI:  result = src1 | src2;
      isa_pkg::OP_XORI: result = src1 ^ src2;
      isa_pkg::OP_MOVI: result = src2;
      default:          result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== regfile.sv ====
`include "cpu_defines.svh"
`default_nettype none

module regfile (
  input  logic              clk,
  input  logic              rst,
  input  logic              write,
  input  isa_pkg::reg_idx_t read_addr1,
  input  isa_pkg::reg_idx_t read_addr2,
  input  isa_pkg::reg_idx_t addr_t,
  input  isa_pkg::word_t    write_data,
  output isa_pkg::word_t    read_data1,
  output isa_pkg::word_t    read_data2,
  output isa_pkg::word_t    read_data_t
);
  isa_pkg::word_t regs [`REG_CNT];

  // rt doubles as the store source.
  assign read_data1  = regs[read_addr1];
  assign read_data2  = regs[read_addr2];
  assign read_data_t = regs[addr_t];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write) begin
      regs[addr_t] <= write_data;
    end
  end

endmodule

`default_nettype wire

// ==== ir_controller.sv ====
`include "cpu_defines.svh"
`default_nettype none

module ir_controller (
  input  logic               clk,
  input  logic               rst,
  input  logic               system_enable,
  input  isa_pkg::word_t     instruction,
  output logic               im_en,
  output logic               im_read,
  output core_pkg::pc_t      im_addr,
  output logic               dm_en,
  output logic               dm_read,
  output logic               dm_write,
  output logic               reg_write,
  output isa_pkg::reg_idx_t  read_addr1,
  output isa_pkg::reg_idx_t  read_addr2,
  output isa_pkg::reg_idx_t  addr_t,
  output isa_pkg::opcode_e   opcode,
  output isa_pkg::alu_sub_e  sub_op,
  output isa_pkg::sv_t       sv,
  output isa_pkg::imm5_t     imm5,
  output isa_pkg::imm15_t    imm15,
  output isa_pkg::imm20_t    imm20,
  output core_pkg::imm_sel_e imm_sel,
  output core_pkg::src_sel_e src_sel1,
  output core_pkg::src_sel_e src_sel2,
  output core_pkg::wb_sel_e  wb_sel,
  output logic [`CYCLE_W-1:0] cycle_cnt,
  output logic [`INS_W-1:0]  ins_cnt,
  output logic               halted
);
  core_pkg::ctrl_state_e state;
  core_pkg::ctrl_state_e state_next;
  core_pkg::pc_t         pc;
  isa_pkg::word_t        ir;
  isa_pkg::opcode_e      fetched_op;
  logic                  is_shift;
  logic                  wb_in_exec;
  logic                  retire;

  // fields of the latched instruction.
  assign opcode     = isa_pkg::opcode_e'(ir[30:25]);
  assign addr_t     = ir[24:20];
  assign read_addr1 = ir[19:15];
  assign read_addr2 = ir[14:10];
  assign imm5       = ir[14:10];
  assign imm15      = ir[14:0];
  assign imm20      = ir[19:0];
  assign sv         = ir[9:8];
  assign sub_op     = isa_pkg::alu_sub_e'(ir[4:0]);

  // halt is detected on the memory word, before it is latched.
  assign fetched_op = isa_pkg::opcode_e'(instruction[30:25]);
  assign is_shift = sub_op inside {isa_pkg::SUB_SLLI, isa_pkg::SUB_SRLI, isa_pkg::SUB_ROTRI};

  always_comb begin
    imm_sel    = core_pkg::IMM_SE15;
    src_sel1   = core_pkg::SRC_REG;
    src_sel2   = core_pkg::SRC_IMM;
    wb_sel     = core_pkg::WB_ALU;
    wb_in_exec = 1'b0;
    case (opcode)
      isa_pkg::OP_ALU: begin
        wb_in_exec = 1'b1;
        if (is_shift) begin
          imm_sel = core_pkg::IMM_ZE5;
        end else begin
          src_sel2 = core_pkg::SRC_REG;
        end
      end
      isa_pkg::OP_ADDI: wb_in_exec = 1'b1;
      isa_pkg::OP_ORI, isa_pkg::OP_XORI: begin
        imm_sel    = core_pkg::IMM_ZE15;
        wb_in_exec = 1'b1;
      end
      isa_pkg::OP_MOVI: begin
        imm_sel    = core_pkg::IMM_SE20;
        src_sel1   = core_pkg::SRC_ZERO;
        wb_in_exec = 1'b1;
      end
      isa_pkg::OP_LWI: wb_sel = core_pkg::WB_DMEM;
      default: ;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      core_pkg::ST_IDLE: begin
        if (system_enable) begin
          state_next = core_pkg::ST_FETCH;
        end
      end
      core_pkg::ST_FETCH: state_next = core_pkg::ST_DECODE;
      core_pkg::ST_DECODE: begin
        state_next = (fetched_op == isa_pkg::OP_HALT) ? core_pkg::ST_HALT : core_pkg::ST_EXEC;
      end
      core_pkg::ST_EXEC: begin
        if (opcode == isa_pkg::OP_LWI || opcode == isa_pkg::OP_SWI) begin
          state_next = core_pkg::ST_MEM;
        end else begin
          state_next = core_pkg::ST_FETCH;
        end
      end
      core_pkg::ST_MEM: begin
        state_next = (opcode == isa_pkg::OP_LWI) ? core_pkg::ST_WB : core_pkg::ST_FETCH;
      end
      core_pkg::ST_WB: state_next = core_pkg::ST_FETCH;
      core_pkg::ST_HALT: state_next = core_pkg::ST_HALT;
      default: state_next = core_pkg::ST_IDLE;
    endcase
  end

  assign retire = (state_next == core_pkg::ST_FETCH) &&
                  (state inside {core_pkg::ST_EXEC, core_pkg::ST_MEM, core_pkg::ST_WB});

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= core_pkg::ST_IDLE;
      pc        <= '0;
      cycle_cnt <= '0;
      ins_cnt   <= '0;
    end else begin
      state <= state_next;
      if (state == core_pkg::ST_FETCH) begin
        pc <= pc + 1'b1;
      end
      if (state != core_pkg::ST_IDLE && state != core_pkg::ST_HALT) begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end
      if (retire) begin
        ins_cnt <= ins_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == core_pkg::ST_DECODE) begin
      ir <= instruction;
    end
  end

  // one-cycle strobes straight from the state.
  assign im_en     = (state == core_pkg::ST_FETCH);
  assign im_read   = (state == core_pkg::ST_FETCH);
  assign im_addr   = pc;
  assign dm_en     = (state == core_pkg::ST_MEM);
  assign dm_read   = dm_en && (opcode == isa_pkg::OP_LWI);
  assign dm_write  = dm_en && (opcode == isa_pkg::OP_SWI);
  assign reg_write = ((state == core_pkg::ST_EXEC) && wb_in_exec) || (state == core_pkg::ST_WB);
  assign halted    = (state == core_pkg::ST_HALT);

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
`include "cpu_defines.svh"
`default_nettype none

package core_pkg;

  typedef logic [`IM_ADDR_W-1:0] pc_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DECODE,
    ST_EXEC,
    ST_MEM,
    ST_WB,
    ST_HALT
  } ctrl_state_e;

  typedef enum logic [1:0] {
    IMM_ZE5,
    IMM_SE15,
    IMM_ZE15,
    IMM_SE20
  } imm_sel_e;

  typedef enum logic [1:0] {
    SRC_REG,
    SRC_IMM,
    SRC_ZERO
  } src_sel_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_DMEM
  } wb_sel_e;

endpackage

`default_nettype wire

// ==== isa_pkg.sv ====
`include "cpu_defines.svh"
`default_nettype none

// bit 31 is zero in every instruction.
// opcode [30:25], rt [24:20], ra [19:15], rb or imm5 [14:10].
// sv [9:8], alu sub-opcode [4:0], imm15 [14:0], imm20 [19:0].
// lwi and swi address ra + (sign-extended imm15 << sv); swi stores rt.
// any word with opcode OP_HALT stops the core.
package isa_pkg;

  typedef logic [`DATA_W-1:0] word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
  typedef logic [1:0] sv_t;
  typedef logic [4:0] imm5_t;
  typedef logic [14:0] imm15_t;
  typedef logic [19:0] imm20_t;

  typedef enum logic [5:0] {
    OP_LWI  = 6'b000010,
    OP_SWI  = 6'b001010,
    OP_ALU  = 6'b100000,
    OP_MOVI = 6'b100010,
    OP_ADDI = 6'b101000,
    OP_XORI = 6'b101011,
    OP_ORI  = 6'b101100,
    OP_HALT = 6'b111111
  } opcode_e;

  // sub-opcodes of OP_ALU.
  typedef enum logic [4:0] {
    SUB_ADD   = 5'b00000,
    SUB_SUB   = 5'b00001,
    SUB_AND   = 5'b00010,
    SUB_XOR   = 5'b00011,
    SUB_OR    = 5'b00100,
    SUB_SLLI  = 5'b01000,
    SUB_SRLI  = 5'b01001,
    SUB_ROTRI = 5'b01011
  } alu_sub_e;

endpackage

`default_nettype wire

// ==== cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// word width of registers, ALU and data memory.
`define DATA_W 32

// register file geometry.
`define REG_ADDR_W 5
`define REG_CNT 32

// instruction memory is word addressed.
`define IM_ADDR_W 10

// data memory is byte addressed by the low ALU result bits.
`define DM_ADDR_W 12

// status counters.
`define CYCLE_W 64
`define INS_W 32

`endif
